//--- hdl/cpuPkg.sv
package cpuPkg;

  //////////////////////////////
  // Basic vector types
  //////////////////////////////
  typedef logic [15:0] word;          // Data, address and instruction word
  typedef logic [3:0]  regIdx;        // Register number
  typedef logic [3:0]  opcode;        // Instruction opcode field

  //////////////////////////////
  // Opcodes
  //////////////////////////////
  localparam opcode opAdd = 4'd0;     // rd = rs + rt
  localparam opcode opSub = 4'd1;     // rd = rs - rt
  localparam opcode opXor = 4'd2;     // rd = rs ^ rt
  localparam opcode opSll = 4'd3;     // Logical left shift by imm4
  localparam opcode opSra = 4'd4;     // Arithmetic right shift by imm4
  localparam opcode opLw  = 4'd8;     // Load word
  localparam opcode opSw  = 4'd9;     // Store word
  localparam opcode opLlb = 4'd10;    // Load sign-extended low byte
  localparam opcode opLhb = 4'd11;    // Replace high byte
  localparam opcode opB   = 4'd12;    // Conditional branch
  localparam opcode opPcs = 4'd14;    // rd = pc + 2
  localparam opcode opHlt = 4'd15;    // Stop the core

  //////////////////////////////
  // Branch conditions
  //////////////////////////////
  localparam logic [2:0] condNe     = 3'd0;  // Z clear
  localparam logic [2:0] condEq     = 3'd1;  // Z set
  localparam logic [2:0] condGt     = 3'd2;  // Z and N clear
  localparam logic [2:0] condLt     = 3'd3;  // N set
  localparam logic [2:0] condGe     = 3'd4;  // Z set, or Z and N clear
  localparam logic [2:0] condLe     = 3'd5;  // Z or N set
  localparam logic [2:0] condOvf    = 3'd6;  // V set
  localparam logic [2:0] condAlways = 3'd7;  // Unconditional

  // Memory geometry, word addressed through addr[memIdxW:1]
  localparam int  imemDepth = 256;
  localparam int  dmemDepth = 256;
  localparam int  memIdxW   = 8;
  localparam word resetPc   = 16'h0000;

  //////////////////////////////
  // Pipeline records
  //////////////////////////////
  typedef struct packed {
    logic z;                          // Zero
    logic n;                          // Negative
    logic v;                          // Signed overflow
  } flagsT;

  typedef struct packed {
    logic  valid;
    opcode aluOp;
    word   in1;                       // Port A operand
    word   in2;                       // Port B operand or immediate
    logic  zEn;                       // Update Z
    logic  nvEn;                      // Update N and V
    logic  memEn;
    logic  memWr;
    word   storeData;                 // SW data register value
    logic  regWr;
    regIdx rd;
    logic  memToReg;                  // LW result from memory
    logic  pcs;
    logic  halt;
    word   pcNext;                    // Address of this instruction plus 2
  } idExT;

  typedef struct packed {
    logic  valid;
    word   aluOut;
    logic  memEn;
    logic  memWr;
    word   storeData;
    logic  regWr;
    regIdx rd;
    logic  memToReg;
    logic  pcs;
    logic  halt;
    word   pcNext;
  } exMemT;

  typedef struct packed {
    logic  valid;
    word   aluOut;
    word   memData;                   // Data memory read result
    logic  regWr;
    regIdx rd;
    logic  memToReg;
    logic  pcs;
    logic  halt;
    word   pcNext;
  } memWbT;

  typedef struct packed {
    logic  valid;                     // One register write-back this cycle
    regIdx rd;
    word   data;
  } commitT;

endpackage

//--- hdl/fetch.sv
`timescale 1ns/1ps

module fetch import cpuPkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic stall,                 // Hold PC and IF/ID
  input  logic flush,                 // Bubble into IF/ID
  input  logic branchTaken,
  input  word  branchTarget,
  output word  pc,
  output word  ifIdInst,
  output word  ifIdPcNext,
  output logic ifIdValid
);

  word imem [imemDepth];              // Instruction ROM
  word inst;                          // Word at current pc
  word pcPlus2;

  initial begin
    $readmemh("program.hex", imem);
  end

  assign inst    = imem[pc[memIdxW:1]];  // Word aligned read
  assign pcPlus2 = pc + 16'd2;

  //////////////////////////////
  // Program counter
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= resetPc;
    end else if (!stall) begin
      if (branchTaken) pc <= branchTarget;  // Redirect from decode
      else if (!flush) pc <= pcPlus2;       // Flush alone means halt, so pc holds
    end
  end

  //////////////////////////////
  // IF/ID register
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ifIdValid  <= 1'b0;
      ifIdInst   <= '0;
      ifIdPcNext <= '0;
    end else if (!stall) begin
      ifIdValid  <= !flush;               // Squash wrong-path slot
      ifIdInst   <= flush ? '0 : inst;
      ifIdPcNext <= pcPlus2;
    end
  end

endmodule

//--- hdl/decode.sv
`timescale 1ns/1ps

module decode import cpuPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   stall,               // Insert bubble into ID/EX
  input  word    ifIdInst,
  input  word    ifIdPcNext,
  input  logic   ifIdValid,
  input  flagsT  flags,
  input  memWbT  memWb,
  output idExT   idEx,
  output logic   branchTaken,
  output word    branchTarget,
  output regIdx  srcA,
  output regIdx  srcB,
  output logic   useA,
  output logic   useB,
  output logic   isBranch,
  output logic   haltSeen,
  output commitT commit
);

  word   regs [16];                   // Register file with r0 never written
  word   wbData;                      // Selected write-back value
  logic  wbEn;
  opcode op;
  word   rdA;                         // Port A read with bypass
  word   rdB;                         // Port B read with bypass
  idExT  idExNext;
  logic  condMet;
  logic  haltNow;
  logic  haltLatch;                   // Sticky once HLT leaves decode

  //////////////////////////////
  // Write-back and register file
  //////////////////////////////
  assign wbData = memWb.memToReg ? memWb.memData :
                  memWb.pcs      ? memWb.pcNext  : memWb.aluOut;
  assign wbEn   = memWb.valid && memWb.regWr && (memWb.rd != '0);

  assign commit.valid = wbEn;
  assign commit.rd    = memWb.rd;
  assign commit.data  = wbData;

  always_ff @(posedge clk) begin
    if (wbEn) regs[memWb.rd] <= wbData;
  end

  function automatic word readReg(regIdx idx);
    if (idx == '0) return '0;                     // Hardwired zero
    if (wbEn && (memWb.rd == idx)) return wbData; // Write before read
    return regs[idx];
  endfunction

  assign op   = ifIdInst[15:12];
  assign srcA = (op == opLhb) ? ifIdInst[11:8] : ifIdInst[7:4];  // LHB reads its rd
  assign srcB = (op == opSw)  ? ifIdInst[11:8] : ifIdInst[3:0];  // SW data register

  always_comb begin
    rdA = readReg(srcA);
    rdB = readReg(srcB);
  end

  //////////////////////////////
  // Instruction decoder
  //////////////////////////////
  always_comb begin
    idExNext           = '0;
    useA               = 1'b0;
    useB               = 1'b0;
    isBranch           = 1'b0;
    idExNext.valid     = ifIdValid;
    idExNext.aluOp     = op;
    idExNext.in1       = rdA;
    idExNext.in2       = rdB;
    idExNext.storeData = rdB;
    idExNext.rd        = ifIdInst[11:8];
    idExNext.pcNext    = ifIdPcNext;
    case (op)
      opAdd, opSub: begin
        useA = 1'b1;
        useB = 1'b1;
        idExNext.regWr = 1'b1;
        idExNext.zEn   = 1'b1;
        idExNext.nvEn  = 1'b1;
      end
      opXor: begin
        useA = 1'b1;
        useB = 1'b1;
        idExNext.regWr = 1'b1;
        idExNext.zEn   = 1'b1;
      end
      opSll, opSra: begin
        useA = 1'b1;
        idExNext.in2   = {12'h000, ifIdInst[3:0]};   // Shift amount
        idExNext.regWr = 1'b1;
        idExNext.zEn   = 1'b1;
      end
      opLw: begin
        useA = 1'b1;
        idExNext.in2      = {11'd0, ifIdInst[3:0], 1'b0};  // Word offset
        idExNext.memEn    = 1'b1;
        idExNext.memToReg = 1'b1;
        idExNext.regWr    = 1'b1;
      end
      opSw: begin
        useA = 1'b1;
        useB = 1'b1;
        idExNext.in2   = {11'd0, ifIdInst[3:0], 1'b0};
        idExNext.memEn = 1'b1;
        idExNext.memWr = 1'b1;
      end
      opLlb: begin
        idExNext.in2   = {{8{ifIdInst[7]}}, ifIdInst[7:0]};
        idExNext.regWr = 1'b1;
      end
      opLhb: begin
        useA = 1'b1;
        idExNext.in2   = {8'h00, ifIdInst[7:0]};
        idExNext.regWr = 1'b1;
      end
      opB:     isBranch = 1'b1;
      opPcs: begin
        idExNext.regWr = 1'b1;
        idExNext.pcs   = 1'b1;
      end
      opHlt:   idExNext.halt = 1'b1;
      default: ;                                     // Unused opcodes act as NOP
    endcase
  end

  //////////////////////////////
  // Branch resolution
  //////////////////////////////
  always_comb begin
    case (ifIdInst[11:9])
      condNe:  condMet = !flags.z;
      condEq:  condMet = flags.z;
      condGt:  condMet = !flags.z && !flags.n;
      condLt:  condMet = flags.n;
      condGe:  condMet = flags.z || !flags.n;
      condLe:  condMet = flags.z || flags.n;
      condOvf: condMet = flags.v;
      default: condMet = 1'b1;                       // condAlways
    endcase
  end

  assign branchTarget = ifIdPcNext + {{6{ifIdInst[8]}}, ifIdInst[8:0], 1'b0};
  assign branchTaken  = ifIdValid && isBranch && condMet;

  assign haltNow  = ifIdValid && (op == opHlt);
  assign haltSeen = haltNow || haltLatch;            // Keeps fetch frozen after HLT

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) haltLatch <= 1'b0;
    else if (haltNow) haltLatch <= 1'b1;
  end

  // ID/EX register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) idEx <= '0;
    else if (stall) idEx <= '0;                     // Bubble while waiting
    else idEx <= idExNext;
  end

endmodule

//--- hdl/execute.sv
`timescale 1ns/1ps

module execute import cpuPkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  idExT  idEx,
  output flagsT flags,
  output exMemT exMem
);

  word  aluOut;
  logic ovf;                          // Signed overflow of ADD or SUB

  //////////////////////////////
  // ALU
  //////////////////////////////
  always_comb begin
    ovf = 1'b0;
    case (idEx.aluOp)
      opAdd, opLw, opSw: begin
        aluOut = idEx.in1 + idEx.in2;                  // Also the address add
        ovf    = (idEx.in1[15] == idEx.in2[15]) && (aluOut[15] != idEx.in1[15]);
      end
      opSub: begin
        aluOut = idEx.in1 - idEx.in2;                  // Wraps
        ovf    = (idEx.in1[15] != idEx.in2[15]) && (aluOut[15] != idEx.in1[15]);
      end
      opXor:   aluOut = idEx.in1 ^ idEx.in2;
      opSll:   aluOut = idEx.in1 << idEx.in2[3:0];
      opSra:   aluOut = word'($signed(idEx.in1) >>> idEx.in2[3:0]);
      opLlb:   aluOut = idEx.in2;                      // Already sign-extended
      opLhb:   aluOut = {idEx.in2[7:0], idEx.in1[7:0]};
      default: aluOut = '0;
    endcase
  end

  // Flag register, written only by flag-setting instructions
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else if (idEx.valid) begin
      if (idEx.zEn) flags.z <= (aluOut == '0);
      if (idEx.nvEn) begin
        flags.n <= aluOut[15];
        flags.v <= ovf;
      end
    end
  end

  //////////////////////////////
  // EX/MEM register
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exMem <= '0;
    end else begin
      exMem.valid     <= idEx.valid;
      exMem.aluOut    <= aluOut;
      exMem.memEn     <= idEx.memEn;
      exMem.memWr     <= idEx.memWr;
      exMem.storeData <= idEx.storeData;
      exMem.regWr     <= idEx.regWr;
      exMem.rd        <= idEx.rd;
      exMem.memToReg  <= idEx.memToReg;
      exMem.pcs       <= idEx.pcs;
      exMem.halt      <= idEx.halt;
      exMem.pcNext    <= idEx.pcNext;
    end
  end

endmodule

//--- hdl/memoryStage.sv
`timescale 1ns/1ps

module memoryStage import cpuPkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  exMemT exMem,
  output memWbT memWb
);

  word  dmem [dmemDepth];             // Data memory
  word  rdData;                       // Combinational read
  logic retired;                      // HLT has reached write-back

  assign rdData  = dmem[exMem.aluOut[memIdxW:1]];
  assign retired = memWb.valid && memWb.halt;

  always_ff @(posedge clk) begin
    if (exMem.valid && exMem.memEn && exMem.memWr)
      dmem[exMem.aluOut[memIdxW:1]] <= exMem.storeData;
  end

  // MEM/WB register, frozen on HLT so hlt stays high
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memWb <= '0;
    end else if (!retired) begin
      memWb.valid    <= exMem.valid;
      memWb.aluOut   <= exMem.aluOut;
      memWb.memData  <= rdData;
      memWb.regWr    <= exMem.regWr;
      memWb.rd       <= exMem.rd;
      memWb.memToReg <= exMem.memToReg;
      memWb.pcs      <= exMem.pcs;
      memWb.halt     <= exMem.halt;
      memWb.pcNext   <= exMem.pcNext;
    end
  end

endmodule

//--- hdl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*; (
  input  regIdx srcA,
  input  regIdx srcB,
  input  logic  useA,
  input  logic  useB,
  input  logic  isBranch,
  input  logic  haltSeen,
  input  logic  branchTaken,
  input  logic  ifIdValid,
  input  idExT  idEx,
  input  exMemT exMem,
  output logic  stall,
  output logic  flush
);

  logic hazA;                         // Port A waits on a pending write
  logic hazB;                         // Port B waits on a pending write
  logic hazFlags;                     // Branch waits on a flag writer

  // Destination still ahead of write-back
  function automatic logic pending(regIdx src);
    return (idEx.valid && idEx.regWr && (idEx.rd == src)) ||
           (exMem.valid && exMem.regWr && (exMem.rd == src));
  endfunction

  always_comb begin
    hazA = useA && (srcA != '0) && pending(srcA);
    hazB = useB && (srcB != '0) && pending(srcB);
  end

  assign hazFlags = isBranch && idEx.valid && (idEx.zEn || idEx.nvEn);

  assign stall = ifIdValid && (hazA || hazB || hazFlags);
  assign flush = (branchTaken || haltSeen) && !stall;  // Stalled branch retries later

endmodule

//--- hdl/cpu.sv
`timescale 1ns/1ps

module cpu import cpuPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  output logic   hlt,                 // HLT retired
  output word    pc,
  output commitT commit               // Register write-back trace
);

  //////////////////////////////
  // Interstage wires
  //////////////////////////////
  logic  stall;
  logic  flush;
  logic  branchTaken;
  word   branchTarget;
  word   ifIdInst;
  word   ifIdPcNext;
  logic  ifIdValid;
  regIdx srcA;
  regIdx srcB;
  logic  useA;
  logic  useB;
  logic  isBranch;
  logic  haltSeen;
  flagsT flags;
  idExT  idEx;
  exMemT exMem;
  memWbT memWb;

  assign hlt = memWb.valid && memWb.halt;

  fetch u_fetch (
    .clk, .rstN, .stall, .flush, .branchTaken, .branchTarget,
    .pc, .ifIdInst, .ifIdPcNext, .ifIdValid
  );

  decode u_decode (
    .clk, .rstN, .stall, .ifIdInst, .ifIdPcNext, .ifIdValid, .flags, .memWb,
    .idEx, .branchTaken, .branchTarget, .srcA, .srcB, .useA, .useB,
    .isBranch, .haltSeen, .commit
  );

  execute u_execute (
    .clk, .rstN, .idEx, .flags, .exMem
  );

  memoryStage u_memoryStage (
    .clk, .rstN, .exMem, .memWb
  );

  hazardUnit u_hazardUnit (
    .srcA, .srcB, .useA, .useB, .isBranch, .haltSeen, .branchTaken,
    .ifIdValid, .idEx, .exMem, .stall, .flush
  );

endmodule

//--- testbench/cpu_props.sv
`timescale 1ns/1ps

module cpu_props import cpuPkg::*; (
  input logic   clk,
  input logic   rstN,
  input logic   hlt,                  // Core stopped
  input word    pc,
  input commitT commit                // Write-back trace
);

  //////////////////////////////
  // Halt behavior
  //////////////////////////////
  hltSticky: assert property (@(posedge clk) disable iff (!rstN) hlt |=> hlt)
    else $error("hlt fell while the core was out of reset");

  hltNoCommit: assert property (@(posedge clk) disable iff (!rstN) hlt |-> !commit.valid)
    else $error("register write-back seen while hlt is high");

  hltPcStable: assert property (@(posedge clk) disable iff (!rstN) hlt |=> $stable(pc))
    else $error("pc moved while hlt is high");

  // Outputs quiet while reset is applied
  resetQuiet: assert property (@(posedge clk) !rstN |-> (!hlt && !commit.valid))
    else $error("hlt or commit valid during reset");

endmodule

//--- testbench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

  localparam time         halfPeriod    = 50;            // 100 ns clock
  localparam int          resetCycles   = 4;
  localparam int          commitTimeout = 40;            // Cycles between write-backs
  localparam int          haltTimeout   = 50;
  localparam logic [31:0] lfsrSeed      = 32'h0000_8ae3;
  localparam logic [31:0] lfsrTaps      = 32'hA300_0000; // x^32+x^30+x^26+x^25+1
  localparam word         baseAddr      = 16'h0020;      // LLB r8 immediate
  localparam word         pcsAddr       = 16'h0032;      // PCS at word 25
  localparam word         haltAddr      = 16'h0034;      // HLT at word 26

  logic        clk;
  logic        rstN;
  logic        hlt;
  word         pc;
  commitT      commit;
  logic [31:0] lfsrState;
  word         regModel [16];         // Expected register contents

  cpu u_dut (
    .clk(clk),
    .rstN(rstN),
    .hlt(hlt),
    .pc(pc),
    .commit(commit)
  );

  bind cpu cpu_props u_props (
    .clk(clk),
    .rstN(rstN),
    .hlt(hlt),
    .pc(pc),
    .commit(commit)
  );

  initial clk = 1'b0;
  always #halfPeriod clk = !clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);   // Galois form shifting right
  endfunction

  task automatic takeByte(output logic [7:0] b);
    int i;
    b = '0;
    for (i = 0; i < 8; i++) begin
      b = {b[6:0], lfsrState[0]};                 // First bit ends up in the MSB
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  task automatic checkEq(string what, word got, word expected);
    if (got !== expected) begin
      $display("error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
      $display("Test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic waitCommit(output commitT c);
    int n;
    n = 0;
    c = '0;
    do begin
      @(negedge clk);                             // Trace is stable mid-cycle
      n++;
    end while (!commit.valid && n < commitTimeout);
    if (!commit.valid) begin
      $display("Timeout: no register write-back within %0d cycles", commitTimeout);
      $display("Test failed");
      $fatal(1, "write-back wait timed out");
    end
    c = commit;
  endtask

  task automatic expectWrite(regIdx rd, word value, string what);
    commitT c;
    regModel[rd] = value;
    waitCommit(c);
    checkEq({what, " rd"}, {12'd0, c.rd}, {12'd0, rd});
    checkEq(what, c.data, value);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic arithmeticBlock();
    logic [7:0] loA;
    logic [7:0] hiA;
    logic [7:0] loB;
    logic [7:0] hiB;
    takeByte(loA);                                // Same bytes as in program.hex
    takeByte(hiA);
    takeByte(loB);
    takeByte(hiB);
    expectWrite(4'd1, {{8{loA[7]}}, loA}, "LLB r1");
    expectWrite(4'd1, {hiA, regModel[1][7:0]}, "LHB r1");
    expectWrite(4'd2, {{8{loB[7]}}, loB}, "LLB r2");
    expectWrite(4'd2, {hiB, regModel[2][7:0]}, "LHB r2");
    expectWrite(4'd3, regModel[1] + regModel[2], "ADD r3");
    expectWrite(4'd4, regModel[2] - regModel[1], "SUB r4 wrapped");
    expectWrite(4'd5, regModel[1] ^ regModel[2], "XOR r5");
    expectWrite(4'd6, regModel[1] << 4, "SLL r6");
    expectWrite(4'd7, word'($signed(regModel[4]) >>> 3), "SRA r7");
    // ADD into r0 follows, so the next write-back must be r8
  endtask

  task automatic memoryRoundTrip();
    expectWrite(4'd8, baseAddr, "LLB base r8");
    expectWrite(4'd9, regModel[3], "LW after SW");          // SW stored r3
    expectWrite(4'd10, regModel[9] + regModel[1], "ADD after LW");
  endtask

  task automatic dependenceChain();
    expectWrite(4'd11, regModel[10] + regModel[2], "chain ADD");
    expectWrite(4'd12, regModel[11] ^ regModel[1], "chain XOR");
    expectWrite(4'd13, regModel[12] - regModel[5], "chain SUB");
  endtask

  task automatic branchOutcomes();
    word diff;
    expectWrite(4'd14, 16'h0000, "SUB to zero");            // Sets Z
    expectWrite(4'd15, 16'h0011, "LLB after untaken NE");
    // EQ is taken, so LLB r15 0x33 never shows up
    diff = regModel[1] - regModel[2];
    expectWrite(4'd14, diff, "SUB before GT");
    if (diff == '0 || diff[15]) begin
      expectWrite(4'd14, 16'h0044, "LLB after untaken GT");
    end
    expectWrite(4'd15, pcsAddr + 16'd2, "PCS");
  endtask

  task automatic haltHold();
    int  n;
    word heldPc;
    n = 0;
    while (!hlt && n < haltTimeout) begin
      @(negedge clk);
      n++;
      checkEq("write-back before hlt", {15'd0, commit.valid}, 16'h0000);
    end
    if (!hlt) begin
      $display("Timeout: hlt did not rise within %0d cycles", haltTimeout);
      $display("Test failed");
      $fatal(1, "halt wait timed out");
    end
    heldPc = pc;
    checkEq("pc at halt", heldPc, haltAddr + 16'd2);        // Fetch froze past HLT
    repeat (10) begin
      @(negedge clk);
      checkEq("hlt held", {15'd0, hlt}, 16'h0001);
      checkEq("write-back after hlt", {15'd0, commit.valid}, 16'h0000);
      checkEq("pc after hlt", pc, heldPc);
    end
  endtask

  //////////////////////////////
  // Sequence
  //////////////////////////////
  initial begin
    int i;
    rstN      = 1'b0;
    lfsrState = lfsrSeed;
    for (i = 0; i < 16; i++) begin
      regModel[i] = '0;
    end
    for (i = 0; i < resetCycles; i++) begin
      @(negedge clk);
      checkEq("hlt in reset", {15'd0, hlt}, 16'h0000);
      checkEq("write-back in reset", {15'd0, commit.valid}, 16'h0000);
    end
    rstN = 1'b1;                                  // Released on a falling edge
    arithmeticBlock();
    memoryRoundTrip();
    dependenceChain();
    branchOutcomes();
    haltHold();
    $display("Test passed");
    $finish;
  end

endmodule

//--- testbench/program.hex
// One 16-bit instruction per line, word 0 first
// Columns: instruction word, then assembly as a comment
A1C7 // LLB r1, 0xC7
B151 // LHB r1, 0x51
A200 // LLB r2, 0x00
B251 // LHB r2, 0x51
0312 // ADD r3, r1, r2
1421 // SUB r4, r2, r1
2512 // XOR r5, r1, r2
3614 // SLL r6, r1, 4
4743 // SRA r7, r4, 3
0012 // ADD r0, r1, r2
A820 // LLB r8, 0x20
9383 // SW r3, 3(r8)
8983 // LW r9, 3(r8)
0A91 // ADD r10, r9, r1
0BA2 // ADD r11, r10, r2
2CB1 // XOR r12, r11, r1
1DC5 // SUB r13, r12, r5
1E22 // SUB r14, r2, r2
C001 // B NE, +1
AF11 // LLB r15, 0x11
C201 // B EQ, +1
AF33 // LLB r15, 0x33
1E12 // SUB r14, r1, r2
C401 // B GT, +1
AE44 // LLB r14, 0x44
EF00 // PCS r15
F000 // HLT

//--- files.f
hdl/cpuPkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memoryStage.sv
hdl/hazardUnit.sv
hdl/cpu.sv
testbench/cpu_props.sv
testbench/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build the cpu testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module cpuTb -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# The instruction ROM is read by file name, so run next to program.hex
(cd testbench && ../obj_dir/VcpuTb) > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$log"; then
  exit 1
fi
exit 0
